// File: uart_rx_macros.svh
/* receiver constants, sized for an 8x baud tick and a 4-bit sample counter
   changing OVERSAMPLE also needs the sample points below moved to match */
`ifndef UART_RX_MACROS_SVH
`define UART_RX_MACROS_SVH

// ----------------------------------------
// oversampling and widths
// ----------------------------------------
`define UART_RX_OVERSAMPLE 8     // baud ticks per bit
`define UART_RX_CNT_W 4          // sample counter width
`define UART_RX_DATA_W 8         // holding register width

// ----------------------------------------
// sample points of the counter
// ----------------------------------------
`define UART_RX_BIT_SAMPLE 15    // data and parity bits taken here
`define UART_RX_STOP_SAMPLE 14   // stop bit checked here
`define UART_RX_WAIT_LIMIT 6     // end of the wait after the stop bit

// glitch filter depth
`define UART_RX_VOTE_TAPS 3

`endif

// File: uart_rx_cfg_pkg.sv
/* line configuration and status types seen at the receiver ports
   the data type is 8 bits even in 7-bit mode, where bit 7 reads 0 */
`include "uart_rx_macros.svh"

package uart_rx_cfg_pkg;

  // received byte
  typedef logic [`UART_RX_DATA_W-1:0] rx_data_t;

  // ----------------------------------------
  // line setup, sampled once per frame
  // ----------------------------------------
  typedef struct packed {
    logic bit8;         // 8 data bits when set, else 7
    logic parity_en;    // parity bit follows the data
    logic odd_n_even;   // odd parity when set
  } line_cfg_t;

  // ----------------------------------------
  // status levels
  // ----------------------------------------
  typedef struct packed {
    logic receive_full;   // byte waiting in rx_byte
    logic overflow;       // a byte was lost, cleared by a read
    logic parity_err;     // sticky, cleared by clear_parity
    logic framing_error;  // sticky, cleared by clear_framing_error
  } rx_status_t;

endpackage

// File: uart_rx_frame_pkg.sv
/* types used between the frame state machine and the status registers
   not visible at the top-level ports */
`include "uart_rx_macros.svh"

package uart_rx_frame_pkg;

  // counters
  typedef logic [`UART_RX_CNT_W-1:0] sample_cnt_t;  // ticks within a bit
  typedef logic [3:0] bit_cnt_t;                     // bits taken so far

  // ----------------------------------------
  // frame state machine
  // ----------------------------------------
  typedef enum logic [1:0] {
    rx_idle,        // hunting for a start bit
    rx_data_bits,   // shifting in data and parity
    rx_stop_bit,    // checking the stop bit
    rx_wait         // waiting for the line to return high
  } rx_state_e;

  // ----------------------------------------
  // frame event towards the status registers
  // ----------------------------------------
  typedef struct packed {
    logic                     byte_done;   // one clk pulse, data is valid
    uart_rx_cfg_pkg::rx_data_t data;
    logic                     parity_bad;  // valid with byte_done
    logic                     stop_bad;    // separate one clk pulse
  } frame_event_t;

endpackage

// File: rx_sample_filter.sv
/* majority voter over the last three samples of the raw line
   a single bad sample is rejected, at the cost of a few ticks of delay */
`timescale 1ns/1ps
`include "uart_rx_macros.svh"

module rx_sample_filter (
  input  logic clk,
  input  logic aresetn,
  input  logic baud_tick,   // one clk pulse at 8x baud
  input  logic rx,          // raw serial line
  output logic rx_filtered
);

  logic [`UART_RX_VOTE_TAPS-1:0] taps;  // newest sample at the top

  // ----------------------------------------
  // sample shift register
  // ----------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      taps <= '1;  // idle line is high
    end
    else if (baud_tick)
    begin
      taps <= {rx, taps[`UART_RX_VOTE_TAPS-1:1]};
    end
  end

  // two out of three wins
  assign rx_filtered = (taps[0] & taps[1]) |
                       (taps[1] & taps[2]) |
                       (taps[0] & taps[2]);

endmodule

// File: rx_frame_fsm.sv
/* frame decoder on the filtered line: start, 7 or 8 data bits LSB first,
   optional parity, one stop bit; cfg is taken when the start bit is confirmed */
`timescale 1ns/1ps
`include "uart_rx_macros.svh"

module rx_frame_fsm (
  input  logic                            clk,
  input  logic                            aresetn,
  input  logic                            baud_tick,
  input  uart_rx_cfg_pkg::line_cfg_t      cfg,
  input  logic                            rx_filtered,
  output uart_rx_frame_pkg::frame_event_t frame_event
);

  // first sample lands mid-bit, later ones a full bit apart
  localparam uart_rx_frame_pkg::sample_cnt_t cnt_first_bit =
    `UART_RX_BIT_SAMPLE - (`UART_RX_OVERSAMPLE / 2) + 1;
  localparam uart_rx_frame_pkg::sample_cnt_t cnt_next_bit =
    `UART_RX_BIT_SAMPLE - `UART_RX_OVERSAMPLE + 1;

  uart_rx_frame_pkg::rx_state_e   state;
  uart_rx_frame_pkg::sample_cnt_t sample_cnt;
  uart_rx_frame_pkg::bit_cnt_t    bit_cnt;
  uart_rx_frame_pkg::bit_cnt_t    last_bit;    // data bits plus parity
  uart_rx_cfg_pkg::line_cfg_t     frame_cfg;   // cfg held for this frame
  uart_rx_cfg_pkg::rx_data_t      ev_data;
  logic [8:0]                     rx_shift;    // newest bit enters at the top
  logic [8:0]                     shift_aligned;
  logic                           parity_acc;  // xor of all taken bits
  logic                           ev_parity_bad;
  logic                           byte_done;
  logic                           stop_bad;
  logic                           start_ok;
  logic                           take_bit;
  logic                           frame_end;

  // ----------------------------------------
  // decode of the current tick
  // ----------------------------------------
  assign start_ok  = baud_tick && (state == uart_rx_frame_pkg::rx_idle) &&
                     (sample_cnt == `UART_RX_OVERSAMPLE);
  assign take_bit  = baud_tick && (state == uart_rx_frame_pkg::rx_data_bits) &&
                     (sample_cnt == `UART_RX_BIT_SAMPLE);
  assign frame_end = baud_tick && (state == uart_rx_frame_pkg::rx_data_bits) &&
                     !take_bit && (bit_cnt == last_bit);

  // right-align whatever number of bits came in
  assign shift_aligned = rx_shift >> (4'd9 - last_bit);

  // ----------------------------------------
  // state, counters and pulses
  // ----------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      state      <= uart_rx_frame_pkg::rx_idle;
      sample_cnt <= '0;
      bit_cnt    <= '0;
      byte_done  <= 1'b0;
      stop_bad   <= 1'b0;
    end
    else
    begin
      byte_done <= 1'b0;
      stop_bad  <= 1'b0;
      if (baud_tick)
      begin
        case (state)
          uart_rx_frame_pkg::rx_idle:
          begin
            if (start_ok)
            begin
              state      <= uart_rx_frame_pkg::rx_data_bits;
              sample_cnt <= cnt_first_bit;
              bit_cnt    <= '0;
            end
            else if (rx_filtered)
              sample_cnt <= '0;  // line high, start over
            else
              sample_cnt <= sample_cnt + 1'b1;
          end
          uart_rx_frame_pkg::rx_data_bits:
          begin
            if (take_bit)
            begin
              sample_cnt <= cnt_next_bit;
              bit_cnt    <= bit_cnt + 1'b1;
            end
            else
            begin
              sample_cnt <= sample_cnt + 1'b1;
              if (frame_end)
              begin
                byte_done <= 1'b1;
                state     <= uart_rx_frame_pkg::rx_stop_bit;
              end
            end
          end
          uart_rx_frame_pkg::rx_stop_bit:
          begin
            sample_cnt <= sample_cnt + 1'b1;  // wraps to 0 entering rx_wait
            if (sample_cnt == `UART_RX_STOP_SAMPLE)
              stop_bad <= !rx_filtered;
            if (sample_cnt == '1)
              state <= uart_rx_frame_pkg::rx_wait;
          end
          default:
          begin
            // rx_wait, leave as soon as the line is back high
            if (rx_filtered || (sample_cnt == `UART_RX_WAIT_LIMIT))
            begin
              state      <= uart_rx_frame_pkg::rx_idle;
              sample_cnt <= '0;
            end
            else
              sample_cnt <= sample_cnt + 1'b1;
          end
        endcase
      end
    end
  end

  // ----------------------------------------
  // shift register, parity and frame data
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (start_ok)
    begin
      frame_cfg  <= cfg;
      last_bit   <= 4'd7 + {3'b000, cfg.bit8} + {3'b000, cfg.parity_en};
      rx_shift   <= '0;
      parity_acc <= 1'b0;
    end
    else if (take_bit)
    begin
      rx_shift   <= {rx_filtered, rx_shift[8:1]};
      parity_acc <= parity_acc ^ rx_filtered;
    end
    if (frame_end)
    begin
      ev_data       <= {frame_cfg.bit8 & shift_aligned[7], shift_aligned[6:0]};
      ev_parity_bad <= frame_cfg.parity_en & (parity_acc ^ frame_cfg.odd_n_even);
    end
  end

  assign frame_event = '{byte_done:  byte_done,
                         data:       ev_data,
                         parity_bad: ev_parity_bad,
                         stop_bad:   stop_bad};

endmodule

// File: rx_status_regs.sv
/* holding register and sticky flags; no back-pressure, so a byte that
   arrives while the register is still full is dropped and flagged */
`timescale 1ns/1ps

module rx_status_regs (
  input  logic                            clk,
  input  logic                            aresetn,
  input  uart_rx_frame_pkg::frame_event_t frame_event,
  input  logic                            read_rx_byte,
  input  logic                            clear_parity,
  input  logic                            clear_framing_error,
  output uart_rx_cfg_pkg::rx_data_t       rx_byte,
  output uart_rx_cfg_pkg::rx_status_t     status
);

  logic receive_full;
  logic overflow;
  logic parity_err;
  logic framing_error;
  logic load_byte;

  // a read in the same clk frees the register for the new byte
  assign load_byte = frame_event.byte_done && (!receive_full || read_rx_byte);

  // ----------------------------------------
  // holding register, full and overflow
  // ----------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      rx_byte      <= '0;
      receive_full <= 1'b0;
      overflow     <= 1'b0;
    end
    else
    begin
      if (read_rx_byte)
      begin
        receive_full <= 1'b0;
        overflow     <= 1'b0;
      end
      if (load_byte)
      begin
        rx_byte      <= frame_event.data;
        receive_full <= 1'b1;
      end
      else if (frame_event.byte_done)
        overflow <= 1'b1;  // old byte kept
    end
  end

  // ----------------------------------------
  // sticky error flags, set wins over clear
  // ----------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      parity_err    <= 1'b0;
      framing_error <= 1'b0;
    end
    else
    begin
      if (frame_event.byte_done && frame_event.parity_bad)
        parity_err <= 1'b1;
      else if (clear_parity)
        parity_err <= 1'b0;

      if (frame_event.stop_bad)
        framing_error <= 1'b1;
      else if (clear_framing_error)
        framing_error <= 1'b0;
    end
  end

  assign status = '{receive_full:  receive_full,
                    overflow:      overflow,
                    parity_err:    parity_err,
                    framing_error: framing_error};

endmodule

// File: uart_rx_top.sv
/* single-line async receiver, needs a one-clk baud_tick at 8x the bit rate
   cfg changes take effect at the next start bit */
`timescale 1ns/1ps

module uart_rx_top (
  input  logic                        clk,
  input  logic                        aresetn,
  input  logic                        baud_tick,
  input  uart_rx_cfg_pkg::line_cfg_t  cfg,
  input  logic                        rx,
  input  logic                        read_rx_byte,
  input  logic                        clear_parity,
  input  logic                        clear_framing_error,
  output uart_rx_cfg_pkg::rx_data_t   rx_byte,
  output uart_rx_cfg_pkg::rx_status_t status
);

  logic                            rx_filtered;
  uart_rx_frame_pkg::frame_event_t frame_event;

  // glitch filter on the raw line
  rx_sample_filter u_filter (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_tick   (baud_tick),
    .rx          (rx),
    .rx_filtered (rx_filtered)
  );

  rx_frame_fsm u_frame_fsm (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_tick   (baud_tick),
    .cfg         (cfg),
    .rx_filtered (rx_filtered),
    .frame_event (frame_event)
  );

  rx_status_regs u_status (
    .clk                 (clk),
    .aresetn             (aresetn),
    .frame_event         (frame_event),
    .read_rx_byte        (read_rx_byte),
    .clear_parity        (clear_parity),
    .clear_framing_error (clear_framing_error),
    .rx_byte             (rx_byte),
    .status              (status)
  );

endmodule

// File: uart_rx_sva.sv
/* port-level checks on the receiver, bound into every uart_rx_top */
`timescale 1ns/1ps

module uart_rx_sva (
  input logic                        clk,
  input logic                        aresetn,
  input logic                        read_rx_byte,
  input uart_rx_cfg_pkg::rx_status_t status
);

  // a byte can only be lost while one is held
  a_overflow_when_full: assert property (@(posedge clk) disable iff (!aresetn)
    $rose(status.overflow) |-> $past(status.receive_full))
    else $error("overflow rose while receive_full was clear");

  a_clean_after_reset: assert property (@(posedge clk)
    $rose(aresetn) |-> (status == '0))
    else $error("status not zero right after reset release");

  // ----------------------------------------
  // read empties the holding register
  // ----------------------------------------
  a_read_empties: assert property (@(posedge clk) disable iff (!aresetn)
    read_rx_byte |=> !status.receive_full)
    else $error("receive_full still set after read_rx_byte");

endmodule

bind uart_rx_top uart_rx_sva u_sva (
  .clk          (clk),
  .aresetn      (aresetn),
  .read_rx_byte (read_rx_byte),
  .status       (status)
);

// File: uart_rx_checker.sv
/* compares DUT outputs with queued expectations, sampled on the falling clk edge
   entries are handled in order, one at a time */
`timescale 1ns/1ps

module uart_rx_checker (
  input  logic                        clk,
  input  uart_rx_cfg_pkg::rx_data_t   rx_byte,
  input  uart_rx_cfg_pkg::rx_status_t status,
  output int                          error_count,
  output int                          timeout_count,
  output int                          done_count
);

  localparam int rise_timeout  = 1000;  // clks, longer than any frame
  localparam int framing_delay = 96;    // stop bit plus two idle bits

  typedef struct packed {
    logic [1:0]                  kind;    // 0 frame, 1 overflow, 2 status only
    uart_rx_cfg_pkg::rx_data_t   data;
    uart_rx_cfg_pkg::rx_status_t status;
  } expect_t;

  expect_t exp_q[$];
  string   name_q[$];

  function automatic void add_expect(input logic [1:0] kind, input string name,
                                     input uart_rx_cfg_pkg::rx_data_t data,
                                     input uart_rx_cfg_pkg::rx_status_t st);
    exp_q.push_back('{kind: kind, data: data, status: st});
    name_q.push_back(name);
  endfunction

  function automatic void compare(input string name, input string what,
                                  input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act)
    begin
      error_count++;
      $display("[ERROR] %s: %s expected %h, actual %h", name, what, exp, act);
    end
  endfunction

  // ----------------------------------------
  // wait for a new byte or a new overflow
  // ----------------------------------------
  task automatic wait_rise(input logic use_overflow, input string name, output logic seen);
    logic prev;
    logic now;
    int   t;
    prev = use_overflow ? status.overflow : status.receive_full;
    seen = 1'b0;
    for (t = 0; t < rise_timeout && !seen; t++)
    begin
      @(negedge clk);
      now  = use_overflow ? status.overflow : status.receive_full;
      seen = now && !prev;
      prev = now;
    end
    if (!seen)
    begin
      timeout_count++;
      $display("timeout in %s: the DUT never flagged the expected byte", name);
    end
  endtask

  initial
  begin
    expect_t e;
    string   name;
    logic    seen;
    error_count   = 0;
    timeout_count = 0;
    done_count    = 0;
    forever
    begin
      @(negedge clk);
      if (exp_q.size() != 0)
      begin
        e    = exp_q.pop_front();
        name = name_q.pop_front();
        seen = 1'b1;
        if (e.kind != 2'd2)
          wait_rise(e.kind == 2'd1, name, seen);
        if (seen)
        begin
          if (e.kind != 2'd2)
            compare(name, "rx_byte", e.data, rx_byte);
          if (e.kind == 2'd0)
          begin
            compare(name, "parity_err", {7'b0, e.status.parity_err}, {7'b0, status.parity_err});
            compare(name, "overflow", {7'b0, e.status.overflow}, {7'b0, status.overflow});
            repeat (framing_delay) @(negedge clk);  // stop bit is checked by now
            compare(name, "framing_error", {7'b0, e.status.framing_error},
                    {7'b0, status.framing_error});
          end
          else
            compare(name, "status", {4'b0, e.status}, {4'b0, status});
        end
        done_count++;
      end
    end
  end

endmodule

// File: tb_uart_rx.sv
/* testbench for uart_rx_top, baud tick every 4 clks, stimulus from a fixed seed
   all comparisons happen in uart_rx_checker */
`timescale 1ns/1ps
`include "uart_rx_macros.svh"

module tb_uart_rx;

  localparam int bit_clks   = `UART_RX_OVERSAMPLE * 4;
  localparam int wait_limit = 3000;  // clks per checker wait

  logic                        clk;
  logic                        aresetn;
  logic                        baud_tick;
  uart_rx_cfg_pkg::line_cfg_t  cfg;
  logic                        rx;
  logic                        read_rx_byte;
  logic                        clear_parity;
  logic                        clear_framing_error;
  uart_rx_cfg_pkg::rx_data_t   rx_byte;
  uart_rx_cfg_pkg::rx_status_t status;
  logic [1:0]                  tick_div;
  integer                      seed;
  int                          expect_count;
  int                          error_count;
  int                          timeout_count;
  int                          done_count;

  uart_rx_top DUT (
    .clk                 (clk),
    .aresetn             (aresetn),
    .baud_tick           (baud_tick),
    .cfg                 (cfg),
    .rx                  (rx),
    .read_rx_byte        (read_rx_byte),
    .clear_parity        (clear_parity),
    .clear_framing_error (clear_framing_error),
    .rx_byte             (rx_byte),
    .status              (status)
  );

  uart_rx_checker u_checker (
    .clk           (clk),
    .rx_byte       (rx_byte),
    .status        (status),
    .error_count   (error_count),
    .timeout_count (timeout_count),
    .done_count    (done_count)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
  begin
    tick_div  <= tick_div + 1'b1;
    baud_tick <= (tick_div == 2'd3);  // one clk in four
  end

  // ----------------------------------------
  // reference model of one frame
  // ----------------------------------------
  function automatic logic [11:0] expected_result(input uart_rx_cfg_pkg::rx_data_t data,
                                                  input uart_rx_cfg_pkg::line_cfg_t c,
                                                  input logic parity_fault,
                                                  input logic stop_val);
    uart_rx_cfg_pkg::rx_data_t   exp_byte;
    uart_rx_cfg_pkg::rx_status_t st;
    logic                        good_parity;
    logic                        sent_parity;
    exp_byte         = c.bit8 ? data : {1'b0, data[6:0]};
    good_parity      = (^exp_byte) ^ c.odd_n_even;
    sent_parity      = good_parity ^ parity_fault;
    st.receive_full  = 1'b1;
    st.overflow      = 1'b0;
    st.parity_err    = c.parity_en & (sent_parity ^ good_parity);
    st.framing_error = !stop_val;
    return {exp_byte, st};
  endfunction

  task automatic send_frame(input uart_rx_cfg_pkg::rx_data_t data,
                            input uart_rx_cfg_pkg::line_cfg_t c,
                            input logic parity_fault, input logic stop_val);
    logic [10:0] bits;  // start at bit 0
    int          n;
    int          i;
    n    = c.bit8 ? 8 : 7;
    bits = {2'b00, data, 1'b0};
    if (c.parity_en)
      bits[n + 1] = (^(data & (c.bit8 ? 8'hff : 8'h7f))) ^ c.odd_n_even ^ parity_fault;
    bits[n + 1 + c.parity_en] = stop_val;
    @(posedge clk);
    cfg <= c;
    for (i = 0; i <= n + 1 + c.parity_en; i++)
    begin
      rx <= bits[i];
      repeat (bit_clks) @(posedge clk);
    end
    rx <= 1'b1;
  endtask

  task automatic pulse_strobe(input int sel);  // 0 read, 1 parity, 2 framing
    @(posedge clk);
    read_rx_byte        <= (sel == 0);
    clear_parity        <= (sel == 1);
    clear_framing_error <= (sel == 2);
    @(posedge clk);
    read_rx_byte        <= 1'b0;
    clear_parity        <= 1'b0;
    clear_framing_error <= 1'b0;
  endtask

  task automatic finish_run(input logic timed_out);
    $display("checks %0d, value errors %0d, timeouts %0d",
             done_count, error_count, timeout_count);
    if (!timed_out && error_count == 0 && timeout_count == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic wait_checker();
    int t;
    for (t = 0; t < wait_limit && done_count != expect_count; t++)
      @(posedge clk);
    if (done_count != expect_count)
    begin
      $display("timeout: checker did not finish within %0d clks", wait_limit);
      finish_run(1'b1);
    end
  endtask

  task automatic add_check(input logic [1:0] kind, input string name,
                           input uart_rx_cfg_pkg::rx_data_t data,
                           input uart_rx_cfg_pkg::rx_status_t st);
    u_checker.add_expect(kind, name, data, st);
    expect_count++;
  endtask

  task automatic check_status(input string name, input uart_rx_cfg_pkg::rx_status_t st);
    add_check(2'd2, name, '0, st);
    wait_checker();
  endtask

  task automatic run_frame(input string name, input uart_rx_cfg_pkg::rx_data_t data,
                           input uart_rx_cfg_pkg::line_cfg_t c, input logic parity_fault,
                           input logic stop_val, input logic do_read);
    logic [11:0] exp;
    exp = expected_result(data, c, parity_fault, stop_val);
    add_check(2'd0, name, exp[11:4], exp[3:0]);
    send_frame(data, c, parity_fault, stop_val);
    repeat (2 * bit_clks) @(posedge clk);  // two idle bits
    wait_checker();
    if (do_read)
      pulse_strobe(0);
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial
  begin
    uart_rx_cfg_pkg::rx_data_t  data;
    uart_rx_cfg_pkg::rx_data_t  data2;
    uart_rx_cfg_pkg::line_cfg_t c;
    int                         i;
    seed                = 32'hf1ed5c1d;
    expect_count        = 0;
    tick_div            = 2'd0;
    aresetn             = 1'b0;
    baud_tick           = 1'b0;
    cfg                 = '0;
    rx                  = 1'b1;
    read_rx_byte        = 1'b0;
    clear_parity        = 1'b0;
    clear_framing_error = 1'b0;
    repeat (16) @(posedge clk);
    aresetn <= 1'b1;
    repeat (4) @(posedge clk);

    for (i = 0; i < 8; i++)  // every bit8 and parity_en mix, twice
    begin
      data = 8'($random(seed));
      c    = {i[1], i[0], 1'($random(seed))};
      run_frame("random_byte", data, c, 1'b0, 1'b1, 1'b1);
    end

    for (i = 0; i < 2; i++)  // even, then odd
    begin
      data = 8'($random(seed));
      run_frame("parity_fault", data, {1'b1, 1'b1, i[0]}, 1'b1, 1'b1, 1'b1);
      pulse_strobe(1);
      check_status("parity_clear", '0);
    end

    c    = 3'b100;
    data = 8'($random(seed));
    run_frame("framing", data, c, 1'b0, 1'b0, 1'b1);
    pulse_strobe(2);
    check_status("framing_clear", '0);
    data = 8'($random(seed));
    run_frame("after_framing", data, c, 1'b0, 1'b1, 1'b1);

    // second byte lands on a full register
    data  = 8'($random(seed));
    data2 = 8'($random(seed));
    run_frame("overflow_first", data, c, 1'b0, 1'b1, 1'b0);
    add_check(2'd1, "overflow_keep", data, 4'b1100);
    send_frame(data2, c, 1'b0, 1'b1);
    repeat (2 * bit_clks) @(posedge clk);
    wait_checker();
    pulse_strobe(0);
    check_status("overflow_read", '0);

    for (i = 0; i < 4; i++)  // one-clk glitches at each tick phase
    begin
      repeat (bit_clks) @(posedge clk);
      rx <= 1'b0;
      @(posedge clk);
      rx <= 1'b1;
    end
    repeat (2 * bit_clks) @(posedge clk);
    check_status("glitch", '0);
    finish_run(1'b0);
  end

endmodule

// File: files.f
+incdir+.
uart_rx_cfg_pkg.sv
uart_rx_frame_pkg.sv
rx_sample_filter.sv
rx_frame_fsm.sv
rx_status_regs.sv
uart_rx_top.sv
uart_rx_sva.sv
uart_rx_checker.sv
tb_uart_rx.sv

// File: Makefile
TOP = tb_uart_rx

all: run

obj_dir/V$(TOP): files.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing -Wno-fatal -f files.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	! grep -q "TEST RESULT: FAIL" sim.log
	grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
